// ==== hw/busPkg.sv ====
//--------------------------------------------------------------------
// Shared definitions for the Z80-style bus interface
// Bus function and T-state enumerations, bus width constants
//--------------------------------------------------------------------
`default_nettype none

package busPkg;

    // Bus widths
    localparam int AddrWidth = 16;      // Address bus A15..A0
    localparam int DataWidth = 8;       // Data bus D7..D0

    // Bus cycle function requested by the host
    typedef enum logic [2:0] {
        funcFetch,                      // Opcode fetch (M1 cycle)
        funcMemRead,                    // Memory read
        funcMemWrite,                   // Memory write
        funcIoRead,                     // I/O read
        funcIoWrite,                    // I/O write
        funcIntAck                      // Interrupt acknowledge
    } busFuncT;

    // T-state of the current bus cycle
    typedef enum logic [2:0] {
        tIdle,                          // No cycle in progress
        tOne,                           // T1
        tTwo,                           // T2
        tWaitA,                         // First automatic wait, repeats on WAIT
        tWaitB,                         // Second automatic wait, int ack only
        tThree,                         // T3
        tFour                           // T4, fetch and int ack only
    } tStateT;

endpackage

`default_nettype wire

// ==== hw/cycleRegs.sv ====
//--------------------------------------------------------------------
// Cycle register block
// Holds function, address and write data of the accepted bus cycle
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cycleRegs (
    input  wire logic                         setM1,     // Bus clock
    input  wire logic                         rstN,      // Async reset, active low
    input  wire logic                         accept,    // Strobe taken by the sequencer
    input  wire busPkg::busFuncT              startFunc, // Requested function
    input  wire logic [busPkg::AddrWidth-1:0] startAddr, // Requested address
    input  wire logic [busPkg::DataWidth-1:0] startData, // Write data
    output busPkg::busFuncT                   busFunc,   // Function of current cycle
    output logic      [busPkg::AddrWidth-1:0] addr,      // Address of current cycle
    output logic      [busPkg::DataWidth-1:0] wrData     // Write data of current cycle
);

    import busPkg::*;

    //----------------------------------------------------------------
    // Function register
    //----------------------------------------------------------------
    // Steers the sequence length and the pin decode
    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            busFunc <= funcFetch;
        end else if (accept) begin
            busFunc <= startFunc;       // Held until the next accepted strobe
        end
    end

    //----------------------------------------------------------------
    // Address and write data
    //----------------------------------------------------------------
    always_ff @(posedge setM1) begin
        if (accept) begin
            addr   <= startAddr;
            wrData <= startData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tStateSequencer.sv ====
//--------------------------------------------------------------------
// T-state sequencer
// Steps T1..T4 and the automatic wait states of each bus function
// Repeats the current state on hold, marks the last state
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tStateSequencer (
    input  wire logic            setM1,      // Bus clock
    input  wire logic            rstN,       // Async reset, active low
    input  wire logic            cycleStart, // Host start strobe
    input  wire busPkg::busFuncT busFunc,    // Function of current cycle
    input  wire logic            hold,       // WAIT seen in the sample state
    input  wire logic            busack,     // Bus granted away
    output logic                 accept,     // Strobe taken
    output busPkg::tStateT       tState,     // Current T-state
    output logic                 cycleLast,  // Final state of the cycle
    output logic                 busy        // Cycle in progress
);

    import busPkg::*;

    tStateT tNext;
    logic   longCycle;                       // Cycle ends in T4
    logic   autoWait;                        // Cycle has automatic wait states

    assign longCycle = (busFunc == funcFetch) || (busFunc == funcIntAck);
    assign autoWait  = (busFunc == funcIoRead) || (busFunc == funcIoWrite) ||
                       (busFunc == funcIntAck);

    assign busy   = (tState != tIdle);
    assign accept = cycleStart && !busy && !busack; // Other strobes dropped

    // Last state is T4 for long cycles, T3 otherwise
    assign cycleLast = (tState == tFour) || ((tState == tThree) && !longCycle);

    //----------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------
    always_comb begin
        tNext = tState;                      // Hold repeats the state
        if (!hold) begin
            case (tState)
                tIdle:   if (accept) tNext = tOne;
                tOne:    tNext = tTwo;
                tTwo:    tNext = autoWait ? tWaitA : tThree;
                tWaitA:  tNext = (busFunc == funcIntAck) ? tWaitB : tThree;
                tWaitB:  tNext = tThree;
                tThree:  tNext = longCycle ? tFour : tIdle;
                tFour:   tNext = tIdle;
                default: tNext = tIdle;
            endcase
        end
    end

    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            tState <= tIdle;
        end else begin
            tState <= tNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/pinControl.sv ====
//--------------------------------------------------------------------
// Pin control
// Decodes M1, MREQ, IORQ, RD, WR, RFSH from function and T-state
// Samples WAIT and BUSRQ, owns BUSACK, strobes the bus pads
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pinControl (
    input  wire logic            setM1,     // Bus clock
    input  wire logic            rstN,      // Async reset, active low
    input  wire busPkg::busFuncT busFunc,   // Function of current cycle
    input  wire busPkg::tStateT  tState,    // Current T-state
    input  wire logic            cycleLast, // Final state of the cycle
    input  wire logic            busy,      // Cycle in progress
    input  wire logic            mwait,     // WAIT pin
    input  wire logic            busrq,     // BUSRQ pin
    output logic                 m1,        // M1 pin
    output logic                 mreq,      // MREQ pin
    output logic                 iorq,      // IORQ pin
    output logic                 rd,        // RD pin
    output logic                 wr,        // WR pin
    output logic                 rfsh,      // RFSH pin
    output logic                 busack,    // BUSACK pin
    output logic                 pinOe,     // Control pin output enable
    output logic                 abLoad,    // Load address and data latches
    output logic                 dbDrive,   // Drive write data
    output logic                 dbCapture, // Capture read data
    output logic                 hold       // Repeat the current state
);

    import busPkg::*;

    // Function decode
    logic fFetch, fMem, fMemRd, fMemWr, fIoRd, fIoWr, fIo, fIntAck;
    // T-state decode
    logic sT1, sT2, sTwA, sTwB, sT3, sT4;
    logic sampleState;                       // State where WAIT is tested
    logic readCycle;                         // Function returns data

    assign fFetch  = (busFunc == funcFetch);
    assign fMemRd  = (busFunc == funcMemRead);
    assign fMemWr  = (busFunc == funcMemWrite);
    assign fMem    = fMemRd || fMemWr;
    assign fIoRd   = (busFunc == funcIoRead);
    assign fIoWr   = (busFunc == funcIoWrite);
    assign fIo     = fIoRd || fIoWr;
    assign fIntAck = (busFunc == funcIntAck);

    assign sT1  = (tState == tOne);
    assign sT2  = (tState == tTwo);
    assign sTwA = (tState == tWaitA);
    assign sTwB = (tState == tWaitB);
    assign sT3  = (tState == tThree);
    assign sT4  = (tState == tFour);

    //----------------------------------------------------------------
    // Control pin decode
    //----------------------------------------------------------------
    assign m1   = (fFetch  && (sT1 || sT2)) ||
                  (fIntAck && (sT1 || sT2 || sTwA || sTwB));
    assign mreq = (fFetch  && (sT1 || sT2)) ||
                  (fMem    && (sT1 || sT2 || sT3));
    assign rd   = (fFetch  && (sT1 || sT2)) ||
                  (fMemRd  && (sT1 || sT2 || sT3)) ||
                  (fIoRd   && (sT2 || sTwA || sT3));
    assign wr   = (fMemWr  && (sT2 || sT3)) ||
                  (fIoWr   && (sT2 || sTwA || sT3));
    assign iorq = (fIo     && (sT2 || sTwA || sT3)) ||
                  (fIntAck && (sTwB || sT3));
    assign rfsh = fFetch && (sT3 || sT4);   // Refresh window after fetch

    //----------------------------------------------------------------
    // WAIT sampling
    //----------------------------------------------------------------
    assign sampleState = ((fFetch || fMem) && sT2) ||
                         (fIo && sTwA) ||
                         (fIntAck && sTwB);
    assign hold = sampleState && mwait;      // Stretch while device not ready

    assign readCycle = fFetch || fMemRd || fIoRd || fIntAck;
    assign dbCapture = sampleState && !mwait && readCycle; // Last repetition only

    // Pad strobes
    assign abLoad  = sT1;                    // Address out from T2 on
    assign dbDrive = wr;                     // Data driven across the WR window

    //----------------------------------------------------------------
    // BUSRQ / BUSACK
    //----------------------------------------------------------------
    // Sampled at cycle end or while idle, so a running cycle completes
    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            busack <= 1'b0;
        end else if (cycleLast || !busy) begin
            busack <= busrq;
        end
    end

    assign pinOe = !busack;                  // Pins released to the bus master

endmodule

`default_nettype wire

// ==== hw/busPads.sv ====
//--------------------------------------------------------------------
// Bus pads
// Address latch, data output latch, read data capture
// Pad output enables
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module busPads (
    input  wire logic                         setM1,     // Bus clock
    input  wire logic                         rstN,      // Async reset, active low
    input  wire logic [busPkg::AddrWidth-1:0] addr,      // Cycle address
    input  wire logic [busPkg::DataWidth-1:0] wrData,    // Cycle write data
    input  wire logic                         abLoad,    // Load latches in T1
    input  wire logic                         dbDrive,   // Drive data pads
    input  wire logic                         dbCapture, // Sample data pads
    input  wire logic                         pinOe,     // Bus not granted away
    input  wire logic [busPkg::DataWidth-1:0] dbIn,      // Data pads in
    output logic      [busPkg::AddrWidth-1:0] abOut,     // Address pads out
    output logic                              abOe,      // Address pad enable
    output logic      [busPkg::DataWidth-1:0] dbOut,     // Data pads out
    output logic                              dbOe,      // Data pad enable
    output logic      [busPkg::DataWidth-1:0] readData   // Captured read data
);

    import busPkg::*;

    //----------------------------------------------------------------
    // Output latches
    //----------------------------------------------------------------
    // Pads read low out of reset
    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            abOut <= '0;
            dbOut <= '0;
        end else if (abLoad) begin
            abOut <= addr;               // Stable until the next T1
            dbOut <= wrData;
        end
    end

    // Read data from the final WAIT sample
    always_ff @(posedge setM1) begin
        if (dbCapture) begin
            readData <= dbIn;
        end
    end

    // Enables
    assign abOe = pinOe;                 // Address bus floats under BUSACK
    assign dbOe = dbDrive && pinOe;

endmodule

`default_nettype wire

// ==== hw/busInterfaceTop.sv ====
//--------------------------------------------------------------------
// Bus interface top level
// Cycle registers, T-state sequencer, pin control and bus pads
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module busInterfaceTop (
    input  wire logic                         setM1,      // Bus clock
    input  wire logic                         rstN,       // Async reset, active low
    // Host side
    input  wire logic                         cycleStart, // Start strobe
    input  wire busPkg::busFuncT              startFunc,  // Function
    input  wire logic [busPkg::AddrWidth-1:0] startAddr,  // Address
    input  wire logic [busPkg::DataWidth-1:0] startData,  // Write data
    output logic                              cycleDone,  // Last T-state strobe
    output logic      [busPkg::DataWidth-1:0] readData,   // Valid with cycleDone
    // Control pins
    output logic                              m1,
    output logic                              mreq,
    output logic                              iorq,
    output logic                              rd,
    output logic                              wr,
    output logic                              rfsh,
    output logic                              busack,
    output logic                              pinOe,
    input  wire logic                         mwait,
    input  wire logic                         busrq,
    // Address and data pads
    output logic      [busPkg::AddrWidth-1:0] abOut,
    output logic                              abOe,
    output logic      [busPkg::DataWidth-1:0] dbOut,
    output logic                              dbOe,
    input  wire logic [busPkg::DataWidth-1:0] dbIn
);

    import busPkg::*;

    busFuncT                busFunc;
    tStateT                 tState;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wrData;
    logic                   accept;
    logic                   busy;
    logic                   hold;
    logic                   abLoad;
    logic                   dbDrive;
    logic                   dbCapture;

    cycleRegs u_cycleRegs (
        .setM1, .rstN, .accept, .startFunc, .startAddr, .startData,
        .busFunc, .addr, .wrData
    );

    tStateSequencer u_tStateSequencer (
        .setM1, .rstN, .cycleStart, .busFunc, .hold, .busack,
        .accept, .tState, .cycleLast(cycleDone), .busy
    );

    pinControl u_pinControl (
        .setM1, .rstN, .busFunc, .tState, .cycleLast(cycleDone), .busy,
        .mwait, .busrq, .m1, .mreq, .iorq, .rd, .wr, .rfsh, .busack,
        .pinOe, .abLoad, .dbDrive, .dbCapture, .hold
    );

    busPads u_busPads (
        .setM1, .rstN, .addr, .wrData, .abLoad, .dbDrive, .dbCapture,
        .pinOe, .dbIn, .abOut, .abOe, .dbOut, .dbOe, .readData
    );

endmodule

`default_nettype wire

// ==== sim/busInterfaceChecker.sv ====
//--------------------------------------------------------------------
// Bus interface checker, bound into the top level
// Cycle model driven by the host strobe and WAIT
// Concurrent assertions on pins, host strobes, pads and BUSACK
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module busInterfaceChecker (
    input wire logic                         setM1,
    input wire logic                         rstN,
    input wire logic                         cycleStart,
    input wire busPkg::busFuncT              startFunc,
    input wire logic [busPkg::AddrWidth-1:0] startAddr,
    input wire logic [busPkg::DataWidth-1:0] startData,
    input wire logic                         cycleDone,
    input wire logic [busPkg::DataWidth-1:0] readData,
    input wire logic                         m1,
    input wire logic                         mreq,
    input wire logic                         iorq,
    input wire logic                         rd,
    input wire logic                         wr,
    input wire logic                         rfsh,
    input wire logic                         busack,
    input wire logic                         pinOe,
    input wire logic                         mwait,
    input wire logic                         busrq,
    input wire logic [busPkg::AddrWidth-1:0] abOut,
    input wire logic                         abOe,
    input wire logic [busPkg::DataWidth-1:0] dbOut,
    input wire logic                         dbOe
);

    import busPkg::*;

    int                   errorCount = 0;    // Failed assertions so far
    logic                 mActive;           // Model cycle in progress
    logic                 mBusack;           // Expected BUSACK
    logic [2:0]           mStep;             // Index into the state list
    busFuncT              mFunc;
    logic [AddrWidth-1:0] mAddr;
    logic [DataWidth-1:0] mData;
    tStateT               expState;
    tStateT               sampleState;       // Where WAIT is tested
    logic                 expDone;
    logic                 readCycle;
    logic [5:0]           pinsNow;           // m1 mreq iorq rd wr rfsh
    logic [5:0]           expPins;

    // State list of each function, tIdle past the end
    function automatic tStateT stepState(input busFuncT f, input logic [2:0] step);
        tStateT seq [8];
        case (f)
            funcFetch:
                seq = '{tOne, tTwo, tThree, tFour, tIdle, tIdle, tIdle, tIdle};
            funcIoRead, funcIoWrite:
                seq = '{tOne, tTwo, tWaitA, tThree, tIdle, tIdle, tIdle, tIdle};
            funcIntAck:
                seq = '{tOne, tTwo, tWaitA, tWaitB, tThree, tFour, tIdle, tIdle};
            default:                         // Memory read and write
                seq = '{tOne, tTwo, tThree, tIdle, tIdle, tIdle, tIdle, tIdle};
        endcase
        return seq[step];
    endfunction

    // Pin windows per function
    function automatic logic [5:0] pinsFor(input busFuncT f, input tStateT s);
        logic early;                         // T1 and T2
        logic mid;                           // T2 through T3
        early = (s == tOne) || (s == tTwo);
        mid   = (s == tTwo) || (s == tWaitA) || (s == tThree);
        case (f)
            funcFetch:    return {early, early, 1'b0, early, 1'b0, s == tThree || s == tFour};
            funcMemRead:  return {1'b0, early || s == tThree, 1'b0, early || s == tThree, 2'b00};
            funcMemWrite: return {1'b0, early || s == tThree, 2'b00, mid, 1'b0};
            funcIoRead:   return {2'b00, mid, mid, 2'b00};
            funcIoWrite:  return {2'b00, mid, 1'b0, mid, 1'b0};
            default:      return {early || s == tWaitA || s == tWaitB, 1'b0,
                                  s == tWaitB || s == tThree, 3'b000};
        endcase
    endfunction

    assign expState  = mActive ? stepState(mFunc, mStep) : tIdle;
    assign expDone   = mActive && (stepState(mFunc, mStep + 3'd1) == tIdle);
    assign expPins   = pinsFor(mFunc, expState);
    assign pinsNow   = {m1, mreq, iorq, rd, wr, rfsh};
    assign readCycle = (mFunc != funcMemWrite) && (mFunc != funcIoWrite);

    always_comb begin
        case (mFunc)
            funcIoRead, funcIoWrite: sampleState = tWaitA;
            funcIntAck:              sampleState = tWaitB;
            default:                 sampleState = tTwo;
        endcase
    end

    //----------------------------------------------------------------
    // Cycle model
    //----------------------------------------------------------------
    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            mActive <= 1'b0;
            mBusack <= 1'b0;
            mStep   <= 3'd0;
            mFunc   <= funcFetch;
            mAddr   <= '0;
            mData   <= '0;
        end else begin
            if (!mActive || expDone) begin
                mBusack <= busrq;            // Grant only between cycles
            end
            if (!mActive) begin
                if (cycleStart && !mBusack) begin
                    mActive <= 1'b1;
                    mStep   <= 3'd0;
                    mFunc   <= startFunc;
                    mAddr   <= startAddr;
                    mData   <= startData;
                end
            end else if (expState == sampleState && mwait) begin
                mStep <= mStep;              // WAIT repeats the sample state
            end else if (expDone) begin
                mActive <= 1'b0;
            end else begin
                mStep <= mStep + 3'd1;
            end
        end
    end

    //----------------------------------------------------------------
    // Assertions
    //----------------------------------------------------------------
    aReset: assert property (@(posedge setM1)
        !rstN |-> pinsNow == 6'b0 && !busack && !cycleDone && pinOe && abOe) else begin
        errorCount++;
        $error("CHECK FAILED reset pins %h busack %h pinOe %h abOe %h", $sampled(pinsNow),
               $sampled(busack), $sampled(pinOe), $sampled(abOe));
    end
    aPins: assert property (@(posedge setM1) disable iff (!rstN) pinsNow == expPins) else begin
        errorCount++;
        $error("CHECK FAILED pins got %h expected %h", $sampled(pinsNow), $sampled(expPins));
    end
    aExcl: assert property (@(posedge setM1) disable iff (!rstN)
        !(rd && wr) && !(mreq && iorq)) else begin
        errorCount++;
        $error("Read and write strobes or memory and I/O requests asserted together");
    end
    aDone: assert property (@(posedge setM1) disable iff (!rstN) cycleDone == expDone) else begin
        errorCount++;
        $error("CHECK FAILED cycleDone got %h expected %h", $sampled(cycleDone),
               $sampled(expDone));
    end
    aRead: assert property (@(posedge setM1) disable iff (!rstN)
        cycleDone && mActive && readCycle |-> readData == (mAddr[7:0] ^ 8'h5A)) else begin
        errorCount++;
        $error("CHECK FAILED readData got %h expected %h", $sampled(readData),
               $sampled(mAddr[7:0] ^ 8'h5A));
    end
    aWrite: assert property (@(posedge setM1) disable iff (!rstN)
        mActive && wr |-> dbOe && dbOut == mData) else begin
        errorCount++;
        $error("CHECK FAILED dbOut got %h expected %h dbOe %h", $sampled(dbOut),
               $sampled(mData), $sampled(dbOe));
    end
    aAddr: assert property (@(posedge setM1) disable iff (!rstN)
        mActive && mStep != 3'd0 |-> abOut == mAddr) else begin
        errorCount++;
        $error("CHECK FAILED abOut got %h expected %h", $sampled(abOut), $sampled(mAddr));
    end
    aBusack: assert property (@(posedge setM1) disable iff (!rstN) busack == mBusack) else begin
        errorCount++;
        $error("CHECK FAILED busack got %h expected %h", $sampled(busack), $sampled(mBusack));
    end
    aRelease: assert property (@(posedge setM1) disable iff (!rstN)
        pinOe == !busack && abOe == !busack && !(busack && dbOe)) else begin
        errorCount++;
        $error("CHECK FAILED busack %h with pinOe %h abOe %h dbOe %h", $sampled(busack),
               $sampled(pinOe), $sampled(abOe), $sampled(dbOe));
    end

endmodule

`default_nettype wire

// ==== sim/busInterfaceTb.sv ====
//--------------------------------------------------------------------
// Bus interface testbench
// Clock, reset, LFSR stimulus, memory model, timeout, closing report
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module busInterfaceTb;

    import busPkg::*;

    localparam int NumCycles     = 60;
    localparam int TimeoutCycles = NumCycles * 16 + 200;   // Worst cycle plus slack

    logic                 setM1;
    logic                 rstN;
    logic                 cycleStart;
    busFuncT              startFunc;
    logic [AddrWidth-1:0] startAddr;
    logic [DataWidth-1:0] startData;
    logic                 cycleDone;
    logic [DataWidth-1:0] readData;
    logic                 m1, mreq, iorq, rd, wr, rfsh, busack, pinOe;
    logic                 mwait;
    logic                 busrq;
    logic [AddrWidth-1:0] abOut;
    logic                 abOe;
    logic [DataWidth-1:0] dbOut;
    logic                 dbOe;
    logic [DataWidth-1:0] dbIn;
    logic [15:0]          lfsr;
    int                   cycleCount = 0;

    busInterfaceTop u_dut (
        .setM1, .rstN, .cycleStart, .startFunc, .startAddr, .startData, .cycleDone,
        .readData, .m1, .mreq, .iorq, .rd, .wr, .rfsh, .busack, .pinOe, .mwait, .busrq,
        .abOut, .abOe, .dbOut, .dbOe, .dbIn
    );

    bind busInterfaceTop busInterfaceChecker u_checker (
        .setM1, .rstN, .cycleStart, .startFunc, .startAddr, .startData, .cycleDone,
        .readData, .m1, .mreq, .iorq, .rd, .wr, .rfsh, .busack, .pinOe, .mwait, .busrq,
        .abOut, .abOe, .dbOut, .dbOe
    );

    initial begin
        setM1 = 1'b0;
        forever #2 setM1 = ~setM1;           // 4 ns period
    end

    // Memory and I/O model driven from the address pads
    always @(negedge setM1) begin
        dbIn = (rd || iorq) ? (abOut[7:0] ^ 8'h5A) : 8'h00;
    end

    // Watchdog
    always @(posedge setM1) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d clocks, a bus cycle never completed", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    //----------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------
    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic takeBits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr[0]};
            lfsr  = lfsrNext(lfsr);          // One step per bit
        end
    endtask

    task automatic runCycle(input busFuncT func, input logic [15:0] addr,
                            input logic [7:0] data, input int waits, input logic raiseBusrq);
        int sampleAt;                        // Clocks from T1 to the sample state
        sampleAt = (func == funcIntAck) ? 3 :
                   (func == funcIoRead || func == funcIoWrite) ? 2 : 1;
        @(negedge setM1);
        cycleStart = 1'b1;
        startFunc  = func;
        startAddr  = addr;
        startData  = data;
        @(negedge setM1);
        cycleStart = 1'b0;
        busrq      = raiseBusrq;             // Lands mid-cycle
        repeat (sampleAt) @(negedge setM1);
        if (waits > 0) begin
            mwait = 1'b1;
            repeat (waits) @(negedge setM1);
            mwait = 1'b0;
        end
        while (!cycleDone) @(negedge setM1);
    endtask

    // Strobe while granted away, then release the bus
    task automatic grantBus(input int holdCycles);
        @(negedge setM1);
        cycleStart = 1'b1;
        @(negedge setM1);
        cycleStart = 1'b0;
        repeat (holdCycles) @(negedge setM1);
        busrq = 1'b0;
        repeat (3) @(negedge setM1);
    endtask

    //----------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------
    initial begin
        logic [15:0] funcBits;
        logic [15:0] addrBits;
        logic [15:0] dataBits;
        logic [15:0] waitBits;
        int          errors;
        rstN       = 1'b0;
        cycleStart = 1'b0;
        startFunc  = funcFetch;
        startAddr  = '0;
        startData  = '0;
        mwait      = 1'b0;
        busrq      = 1'b0;
        dbIn       = '0;
        lfsr       = 16'd64178;
        repeat (8) @(negedge setM1);
        rstN = 1'b1;
        for (int i = 0; i < NumCycles; i++) begin
            takeBits(3, funcBits);
            takeBits(16, addrBits);
            takeBits(8, dataBits);
            takeBits(2, waitBits);
            runCycle(busFuncT'(funcBits[2:0] % 3'd6), addrBits, dataBits[7:0],
                     int'(waitBits[1:0]), i == 20 || i == 45);
            if (i == 20 || i == 45) begin
                grantBus(4);
            end
        end
        repeat (4) @(negedge setM1);
        errors = u_dut.u_checker.errorCount;
        $display("Closing report: %0d assertion errors over %0d bus cycles", errors, NumCycles);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== busInterfaceTop.f ====
hw/busPkg.sv
hw/cycleRegs.sv
hw/tStateSequencer.sv
hw/pinControl.sv
hw/busPads.sv
hw/busInterfaceTop.sv
sim/busInterfaceChecker.sv
sim/busInterfaceTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the bus interface testbench with Verilator
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert \
    --top-module busInterfaceTb \
    --Mdir "$buildDir" \
    -f busInterfaceTop.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion failures so the closing report is printed
"./$buildDir/VbusInterfaceTb" +verilator+error+limit+100000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "No errors" "$logFile"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $logFile"
exit 1
